// ==== sim.f ====
+incdir+logic
logic/cmd_pkg.sv
logic/acq_pkg.sv
logic/cmd_receiver.sv
logic/cmd_decoder.sv
logic/acq_trigger.sv
logic/sample_buffer.sv
logic/reply_sender.sv
logic/command_processor.sv
test/tb_command_processor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the command processor testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_command_processor \
	-f sim.f \
	-o tb_command_processor

# the exit status of the simulation decides pass or fail
./obj_dir/tb_command_processor

// ==== test/tb_command_processor.sv ====
//--------------------------------------------------------------------------
// command processor testbench
// table of commands with expected replies, a model of the capture
// buffer for readouts and random back-pressure on the reply stream
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module tb_command_processor
	import acq_pkg::*;
();

	localparam int         NROWS    = 13;
	localparam int         TIMEOUT  = 200;     // cycles allowed per wait
	localparam int         QUIET    = 40;      // silent cycles for no reply
	localparam logic [7:0] BOARD_ID = 8'h5a;

	typedef enum logic [1:0] {PAT_NONE, PAT_RANDOM, PAT_TRIGGER} pattern_e;

	// byte 0 in the low bits, so bits 63:32 read as the length of bytes 7..4
	typedef struct packed {
		logic [63:0] cmd;
		logic [7:0]  burst_n;   // samples driven after the reply
		pattern_e    pattern;
		logic [7:0]  n_words;   // expected reply words
		logic [31:0] first;     // expected word of a single-word reply
	} row_t;

	logic        clk, rstn;
	logic        s_tvalid, s_tready;
	logic [7:0]  s_tdata;
	logic        m_tready, m_tvalid, m_tlast;
	logic [31:0] m_tdata;
	logic [3:0]  m_tkeep;
	logic        sample_valid;
	sample_t     sample;

	row_t        rows [NROWS];
	logic [31:0] lfsr;

	//------------------------------------------------------------------------
	// reference model of the acquisition and the ring buffer
	//------------------------------------------------------------------------
	sample_t                m_mem [`BUF_DEPTH];
	acq_state_e             m_state;
	logic [`BUF_ADDR_W-1:0] m_wr, m_trig, m_preoff;
	logic [`CNT_W-1:0]      m_cnt, m_events, m_len;
	sample_t                m_lower, m_upper;
	logic                   m_thresh;

	command_processor dut0 (
		.clk            (clk),
		.rstn           (rstn),
		.i_s_tvalid     (s_tvalid),
		.i_s_tdata      (s_tdata),
		.o_s_tready     (s_tready),
		.i_m_tready     (m_tready),
		.o_m_tvalid     (m_tvalid),
		.o_m_tdata      (m_tdata),
		.o_m_tkeep      (m_tkeep),
		.o_m_tlast      (m_tlast),
		.i_sample_valid (sample_valid),
		.i_sample       (sample),
		.i_board_id     (BOARD_ID)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_keep(input logic [3:0] keep, input logic last,
	                          input logic [3:0] exp_keep, input logic exp_last);
		if (keep !== exp_keep)
			fail_run($sformatf("error at %0t: o_m_tkeep got %b expected %b",
			                   $time, keep, exp_keep));
		if (last !== exp_last)
			fail_run($sformatf("error at %0t: o_m_tlast got %b expected %b",
			                   $time, last, exp_last));
	endtask

	task automatic check_status(input acq_status_t got, input acq_status_t exp);
		if (got.events !== exp.events)
			fail_run($sformatf("error at %0t: status.events got %h expected %h",
			                   $time, got.events, exp.events));
		if (got.trig_count !== exp.trig_count)
			fail_run($sformatf("error at %0t: status.trig_count got %h expected %h",
			                   $time, got.trig_count, exp.trig_count));
		if (got.trig_addr !== exp.trig_addr)
			fail_run($sformatf("error at %0t: status.trig_addr got %h expected %h",
			                   $time, got.trig_addr, exp.trig_addr));
	endtask

	// galois lfsr stepped once per bit
	function automatic logic rand_bit();
		logic b;
		b    = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic sample_t rand_sample();
		sample_t s;
		for (int i = 0; i < `SAMPLE_W; i++) s[i] = rand_bit();
		return s;
	endfunction

	task automatic model_sample(input sample_t s);
		if (m_state != ACQ_READY) begin       // buffer frozen once ready
			m_mem[m_wr] = s;
			case (m_state)
				ACQ_WAIT_LOW: if (s < m_lower) m_state = ACQ_WAIT_HIGH;
				ACQ_WAIT_HIGH: if (s > m_upper) begin
					m_trig  = m_wr;
					m_state = ACQ_COLLECT;
				end
				ACQ_COLLECT: begin
					if (m_cnt != m_len) begin
						m_cnt = m_cnt + 1'b1;
					end else begin
						m_events = m_events + 1'b1;
						m_cnt    = '1;
						m_state  = ACQ_READY;
					end
				end
				default: ;
			endcase
			m_wr = m_wr + 1'b1;
		end
	endtask

	task automatic model_command(input logic [63:0] cmd);
		int b1, b2;
		b1 = cmd[15:8];
		b2 = cmd[23:16];
		case (cmd[7:0])
			8'd8: begin
				m_lower  = sample_t'((b1 - b2 - 128) * 16 + 8);
				m_upper  = sample_t'((b1 + b2 - 128) * 16 + 8);
				m_preoff = `BUF_ADDR_W'(cmd[31:24] * 4);
			end
			8'd1: begin
				m_thresh = (cmd[15:8] == 8'd1);
				m_len    = cmd[47:32];
				if (m_state == ACQ_IDLE) begin   // arm ignored elsewhere
					if (m_thresh) begin
						m_state = ACQ_WAIT_LOW;
					end else begin
						m_trig  = m_wr;
						m_state = ACQ_COLLECT;
					end
				end
			end
			default: ;
		endcase
	endtask

	//------------------------------------------------------------------------
	// stream drivers and reply collection
	//------------------------------------------------------------------------
	task automatic send_command(input logic [63:0] cmd);
		int wait_n;
		for (int i = 0; i < `CMD_BYTES; i++) begin
			s_tvalid = 1'b1;
			s_tdata  = cmd[8*i +: 8];
			wait_n   = 0;
			while (!s_tready) begin
				wait_n++;
				if (wait_n > TIMEOUT) fail_run("timeout: command byte was not accepted");
				@(posedge clk);
				#1;
			end
			@(posedge clk);                   // byte moves on this edge
			#1;
		end
		s_tvalid = 1'b0;
	endtask

	task automatic collect_reply(input row_t r);
		logic [`LEN_W-1:0]      len, rem;
		logic [`BUF_ADDR_W-1:0] a_even, a_odd;
		logic [31:0]            exp;
		logic [3:0]             exp_keep;
		logic                   readout;
		int                     wait_n;
		readout = (r.cmd[7:0] == 8'd0);
		len     = readout ? r.cmd[63:32] : 32'd4;
		for (int k = 0; k < r.n_words; k++) begin
			wait_n   = 0;
			m_tready = rand_bit();
			while (!(m_tvalid && m_tready)) begin
				wait_n++;
				if (wait_n > TIMEOUT) fail_run("timeout: reply word did not arrive");
				@(posedge clk);
				#1;
				m_tready = rand_bit();
			end
			rem    = len - 32'(4 * k);
			a_even = m_trig - m_preoff + `BUF_ADDR_W'(2 * k);
			a_odd  = a_even + 1'b1;
			exp    = readout ? {4'd0, m_mem[a_odd], 4'd0, m_mem[a_even]} : r.first;
			exp_keep = (rem >= 4) ? 4'b1111 : 4'((1 << rem) - 1);
			check_word("o_m_tdata", m_tdata, exp);
			check_keep(m_tkeep, m_tlast, exp_keep, rem <= 4);
			@(posedge clk);
			#1;
		end
		m_tready = 1'b1;
		if (readout) begin
			wait_n = 0;
			while (!dut0.readout_done) begin  // sender ends the readout
				wait_n++;
				if (m_tvalid) fail_run("a readout sent more words than its length allows");
				if (wait_n > TIMEOUT) fail_run("timeout: readout did not finish");
				@(posedge clk);
				#1;
			end
			@(posedge clk);
			#1;
			if (m_state == ACQ_READY) begin
				m_state = ACQ_IDLE;
				m_cnt   = '0;
			end
		end else if (r.n_words == 0) begin
			for (int i = 0; i < QUIET; i++) begin
				if (m_tvalid) fail_run("a reply came for a command that has no reply");
				@(posedge clk);
				#1;
			end
		end
		m_tready = 1'b0;
	endtask

	task automatic drive_burst(input row_t r);
		sample_t s;
		for (int i = 0; i < r.burst_n; i++) begin
			if (r.pattern == PAT_TRIGGER && i == 0)
				s = m_lower;                  // equal to lower is not below
			else if (r.pattern == PAT_TRIGGER && i == 1)
				s = sample_t'(m_lower - 1);   // one below the lower threshold
			else if (r.pattern == PAT_TRIGGER && i == 2)
				s = m_upper;                  // equal to upper is not above
			else if (r.pattern == PAT_TRIGGER && i == 3)
				s = sample_t'(m_upper + 1);   // one above the upper threshold
			else
				s = rand_sample();
			sample_valid = 1'b1;
			sample       = s;
			model_sample(s);
			@(posedge clk);
			#1;
		end
		sample_valid = 1'b0;
	endtask

	task automatic fill_table();
		rows[0]  = '{64'h00000000_00000002, 8'd0,  PAT_NONE,    8'd1,  32'd16};
		rows[1]  = '{64'h00000000_00000102, 8'd0,  PAT_NONE,    8'd1,  {4{BOARD_ID}}};
		rows[2]  = '{64'h00000000_00000702, 8'd0,  PAT_NONE,    8'd1,  32'd0};
		rows[3]  = '{64'h00000000_03108008, 8'd16, PAT_RANDOM,  8'd1,  32'd37};
		rows[4]  = '{64'h00000010_00000101, 8'd21, PAT_TRIGGER, 8'd1,  32'h0000_0000};
		rows[5]  = '{64'h00000010_00000101, 8'd0,  PAT_NONE,    8'd1,  32'h0001_ffff};
		rows[6]  = '{64'h0000002e_00000000, 8'd0,  PAT_NONE,    8'd12, 32'd0};
		rows[7]  = '{64'h00000010_00000001, 8'd17, PAT_RANDOM,  8'd1,  32'h0001_0000};
		rows[8]  = '{64'h00000010_00000001, 8'd0,  PAT_NONE,    8'd1,  32'h0002_ffff};
		rows[9]  = '{64'h00000000_00000005, 8'd0,  PAT_NONE,    8'd0,  32'd0};
		rows[10] = '{64'h00000000_00000002, 8'd0,  PAT_NONE,    8'd1,  32'd16};
		rows[11] = '{64'h0000002e_00000000, 8'd0,  PAT_NONE,    8'd12, 32'd0};
		rows[12] = '{64'h00000000_00000000, 8'd0,  PAT_NONE,    8'd0,  32'd0};
	endtask

	//------------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------------
	initial begin
		acq_status_t exp_status;
		int          wait_n;
		rstn         = 1'b0;
		s_tvalid     = 1'b0;
		s_tdata      = 8'd0;
		m_tready     = 1'b0;
		sample_valid = 1'b0;
		sample       = '0;
		lfsr         = 32'hbb8c9f89;
		m_state      = ACQ_IDLE;
		m_wr         = '0;
		m_trig       = '0;
		m_preoff     = '0;
		m_cnt        = '0;
		m_events     = '0;
		m_len        = '0;
		m_lower      = '0;
		m_upper      = '0;
		m_thresh     = 1'b0;
		fill_table();
		repeat (2) @(posedge clk);
		#1;
		rstn   = 1'b1;
		wait_n = 0;
		while (!s_tready) begin
			wait_n++;
			if (wait_n > TIMEOUT) fail_run("timeout: receiver never became ready after reset");
			@(posedge clk);
			#1;
		end
		if (m_tvalid) fail_run("reply stream is valid right after reset");
		exp_status = '{events: m_events, trig_count: m_cnt, trig_addr: m_trig};
		check_status(dut0.status, exp_status);

		for (int i = 0; i < NROWS; i++) begin
			send_command(rows[i].cmd);
			model_command(rows[i].cmd);
			collect_reply(rows[i]);
			drive_burst(rows[i]);
			exp_status = '{events: m_events, trig_count: m_cnt, trig_addr: m_trig};
			check_status(dut0.status, exp_status);
		end

		$display("test passed");
		$finish;
	end

endmodule

// ==== logic/command_processor.sv ====
//--------------------------------------------------------------------------
// command processor top
// byte commands in, trigger and capture buffer, 32-bit replies out
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module command_processor
	import cmd_pkg::*;
	import acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	// command bytes from the stream slave
	input  logic        i_s_tvalid,
	input  logic [7:0]  i_s_tdata,
	output logic        o_s_tready,
	// replies on the stream master
	input  logic        i_m_tready,
	output logic        o_m_tvalid,
	output logic [31:0] o_m_tdata,
	output logic [3:0]  o_m_tkeep,
	output logic        o_m_tlast,
	// digitizer side
	input  logic        i_sample_valid,
	input  sample_t     i_sample,
	input  logic [7:0]  i_board_id
);

	cmd_t                   cmd;
	logic                   cmd_valid, cmd_take;
	reply_req_t             reply;
	logic                   reply_valid, reply_take, reply_done, readout_done;
	acq_status_t            status;
	trig_cfg_t              trig_cfg;
	logic                   arm;
	logic                   wr_en;
	logic [`BUF_ADDR_W-1:0] wr_addr, rd_addr;
	sample_t                wr_data;
	logic [`SAMPLE_W-1:0]   rd_data;

	//----------------------------------------------------------------------
	// input side
	//----------------------------------------------------------------------
	cmd_receiver u_rx (
		.clk         (clk),
		.rstn        (rstn),
		.i_s_tvalid  (i_s_tvalid),
		.i_s_tdata   (i_s_tdata),
		.o_s_tready  (o_s_tready),
		.i_cmd_take  (cmd_take),
		.o_cmd_valid (cmd_valid),
		.o_cmd       (cmd)
	);

	//----------------------------------------------------------------------
	// processing: decode, trigger, capture
	//----------------------------------------------------------------------
	cmd_decoder u_dec (
		.clk           (clk),
		.rstn          (rstn),
		.i_cmd_valid   (cmd_valid),
		.i_cmd         (cmd),
		.o_cmd_take    (cmd_take),
		.i_status      (status),
		.i_board_id    (i_board_id),
		.o_arm         (arm),
		.o_trig_cfg    (trig_cfg),
		.o_reply_valid (reply_valid),
		.o_reply       (reply),
		.i_reply_take  (reply_take),
		.i_reply_done  (reply_done)
	);

	acq_trigger u_acq (
		.clk            (clk),
		.rstn           (rstn),
		.i_sample_valid (i_sample_valid),
		.i_sample       (i_sample),
		.i_arm          (arm),
		.i_trig_cfg     (trig_cfg),
		.i_readout_done (readout_done),
		.o_wr_en        (wr_en),
		.o_wr_addr      (wr_addr),
		.o_wr_data      (wr_data),
		.o_status       (status)
	);

	sample_buffer u_buf (
		.clk       (clk),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (wr_data),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	//----------------------------------------------------------------------
	// output side
	//----------------------------------------------------------------------
	reply_sender u_tx (
		.clk            (clk),
		.rstn           (rstn),
		.i_reply_valid  (reply_valid),
		.i_reply        (reply),
		.o_reply_take   (reply_take),
		.o_reply_done   (reply_done),
		.o_readout_done (readout_done),
		.o_rd_addr      (rd_addr),
		.i_rd_data      (rd_data),
		.i_m_tready     (i_m_tready),
		.o_m_tvalid     (o_m_tvalid),
		.o_m_tdata      (o_m_tdata),
		.o_m_tkeep      (o_m_tkeep),
		.o_m_tlast      (o_m_tlast)
	);

endmodule

// ==== logic/reply_sender.sv ====
//--------------------------------------------------------------------------
// reply sender
// stream master for single reply words and buffer readouts,
// tkeep and tlast follow the bytes still to send
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module reply_sender
	import cmd_pkg::*;
(
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   i_reply_valid,
	input  reply_req_t             i_reply,
	output logic                   o_reply_take,
	output logic                   o_reply_done,
	output logic                   o_readout_done,
	output logic [`BUF_ADDR_W-1:0] o_rd_addr,
	input  logic [`SAMPLE_W-1:0]   i_rd_data,
	input  logic                   i_m_tready,
	output logic                   o_m_tvalid,
	output logic [31:0]            o_m_tdata,
	output logic [3:0]             o_m_tkeep,
	output logic                   o_m_tlast
);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_ADDR,       // present the even address
		TX_LOW,        // even sample back, odd address out
		TX_HIGH,       // odd sample back, form the word
		TX_SEND,
		TX_DONE
	} tx_state_e;

	tx_state_e              state;
	logic [`LEN_W-1:0]      remain;
	logic                   readout;
	logic [`BUF_ADDR_W-1:0] rd_addr;
	logic [`SAMPLE_W-1:0]   low_sample;

	assign o_reply_take = (state == TX_IDLE) && i_reply_valid;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= TX_IDLE;
			remain     <= '0;
			readout    <= 1'b0;
			rd_addr    <= '0;
			o_m_tvalid <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: if (o_reply_take) begin
					remain  <= i_reply.len;
					readout <= i_reply.readout;
					rd_addr <= i_reply.start;
					if (i_reply.len == '0) begin
						state <= TX_DONE;             // nothing to send
					end else if (i_reply.readout) begin
						state <= TX_ADDR;
					end else begin
						o_m_tvalid <= 1'b1;
						state      <= TX_SEND;
					end
				end
				TX_ADDR: begin
					rd_addr <= rd_addr + 1'b1;
					state   <= TX_LOW;
				end
				TX_LOW: begin
					rd_addr <= rd_addr + 1'b1;
					state   <= TX_HIGH;
				end
				TX_HIGH: begin
					o_m_tvalid <= 1'b1;
					state      <= TX_SEND;
				end
				TX_SEND: if (i_m_tready) begin
					if (remain <= `LEN_W'(4)) begin
						remain     <= '0;
						o_m_tvalid <= 1'b0;
						state      <= TX_DONE;
					end else begin
						remain <= remain - `LEN_W'(4);
						if (readout) begin
							o_m_tvalid <= 1'b0;
							state      <= TX_ADDR;   // fetch the next pair
						end
					end
				end
				TX_DONE: state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// reply word and readout sample pairs
	always_ff @(posedge clk) begin
		if (o_reply_take) o_m_tdata <= i_reply.word;
		if (state == TX_LOW) low_sample <= i_rd_data;
		if (state == TX_HIGH) o_m_tdata <= {4'd0, i_rd_data, 4'd0, low_sample};
	end

	always_comb begin
		if (remain >= `LEN_W'(4)) begin
			o_m_tkeep = 4'b1111;
		end else begin
			case (remain[1:0])
				2'd3:    o_m_tkeep = 4'b0111;
				2'd2:    o_m_tkeep = 4'b0011;
				2'd1:    o_m_tkeep = 4'b0001;
				default: o_m_tkeep = 4'b0000;
			endcase
		end
	end

	assign o_m_tlast      = (remain <= `LEN_W'(4));
	assign o_rd_addr      = rd_addr;
	assign o_reply_done   = (state == TX_DONE);
	assign o_readout_done = (state == TX_DONE) && readout;

endmodule

// ==== logic/sample_buffer.sv ====
//--------------------------------------------------------------------------
// sample buffer
// ring memory, one write port and one registered read port
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module sample_buffer (
	input  logic                   clk,
	input  logic                   i_wr_en,
	input  logic [`BUF_ADDR_W-1:0] i_wr_addr,
	input  logic [`SAMPLE_W-1:0]   i_wr_data,
	input  logic [`BUF_ADDR_W-1:0] i_rd_addr,
	output logic [`SAMPLE_W-1:0]   o_rd_data
);

	logic [`SAMPLE_W-1:0] mem [`BUF_DEPTH];   // one sample per address

	always_ff @(posedge clk) begin
		if (i_wr_en) mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];            // 1-cycle read latency
	end

endmodule

// ==== logic/acq_trigger.sv ====
//--------------------------------------------------------------------------
// acquisition trigger
// writes samples into the ring buffer and tracks the threshold trigger
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module acq_trigger
	import acq_pkg::*;
(
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   i_sample_valid,
	input  sample_t                i_sample,
	input  logic                   i_arm,
	input  trig_cfg_t              i_trig_cfg,
	input  logic                   i_readout_done,
	output logic                   o_wr_en,
	output logic [`BUF_ADDR_W-1:0] o_wr_addr,
	output sample_t                o_wr_data,
	output acq_status_t            o_status
);

	acq_state_e             state;
	logic [`BUF_ADDR_W-1:0] wr_addr, trig_addr;
	logic [`CNT_W-1:0]      trig_cnt, evt_cnt;

	// keep writing until the event is complete, so pre-trigger data survives
	assign o_wr_en   = i_sample_valid && (state != ACQ_READY);
	assign o_wr_addr = wr_addr;
	assign o_wr_data = i_sample;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= ACQ_IDLE;
			wr_addr   <= '0;
			trig_addr <= '0;
			trig_cnt  <= '0;
			evt_cnt   <= '0;
		end else begin
			if (o_wr_en) wr_addr <= wr_addr + 1'b1;   // wraps at depth
			case (state)
				ACQ_IDLE: begin
					trig_cnt <= '0;
					if (i_arm) begin
						if (i_trig_cfg.thresh_en) begin
							state <= ACQ_WAIT_LOW;
						end else begin
							trig_addr <= wr_addr;   // immediate trigger
							state     <= ACQ_COLLECT;
						end
					end
				end
				ACQ_WAIT_LOW:
					if (i_sample_valid && $signed(i_sample) < $signed(i_trig_cfg.lower))
						state <= ACQ_WAIT_HIGH;
				ACQ_WAIT_HIGH:
					if (i_sample_valid && $signed(i_sample) > $signed(i_trig_cfg.upper)) begin
						trig_addr <= wr_addr;   // address of this sample
						state     <= ACQ_COLLECT;
					end
				ACQ_COLLECT: if (i_sample_valid) begin
					if (trig_cnt != i_trig_cfg.length) begin
						trig_cnt <= trig_cnt + 1'b1;
					end else begin
						evt_cnt  <= evt_cnt + 1'b1;
						trig_cnt <= '1;             // flags event ready
						state    <= ACQ_READY;
					end
				end
				ACQ_READY: begin
					trig_cnt <= '1;
					if (i_readout_done) begin
						trig_cnt <= '0;
						state    <= ACQ_IDLE;
					end
				end
				default: state <= ACQ_IDLE;
			endcase
		end
	end

	assign o_status = '{events: evt_cnt, trig_count: trig_cnt, trig_addr: trig_addr};

endmodule

// ==== logic/cmd_decoder.sv ====
//--------------------------------------------------------------------------
// command decoder
// runs one command at a time, keeps the trigger settings and
// hands a reply request to the sender
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module cmd_decoder
	import cmd_pkg::*;
	import acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  logic        i_cmd_valid,
	input  cmd_t        i_cmd,
	output logic        o_cmd_take,
	input  acq_status_t i_status,
	input  logic [7:0]  i_board_id,
	output logic        o_arm,
	output trig_cfg_t   o_trig_cfg,
	output logic        o_reply_valid,
	output reply_req_t  o_reply,
	input  logic        i_reply_take,
	input  logic        i_reply_done
);

	typedef enum logic [1:0] {
		DEC_IDLE,      // waiting for a command
		DEC_REPLY,     // request posted and not yet taken
		DEC_BUSY       // reply on the wire
	} dec_state_e;

	dec_state_e             state;
	reply_req_t             reply_q;
	trig_cfg_t              cfg_q;
	logic [`BUF_ADDR_W-1:0] preoffset;
	logic [`SAMPLE_W-1:0]   b1_ext, b2_ext, lower_calc, upper_calc;

	// threshold arithmetic wraps at the sample width
	assign b1_ext     = `SAMPLE_W'(i_cmd.arg[1]);
	assign b2_ext     = `SAMPLE_W'(i_cmd.arg[2]);
	assign lower_calc = ((b1_ext - b2_ext - `SAMPLE_W'(128)) << 4) + `SAMPLE_W'(8);
	assign upper_calc = ((b1_ext + b2_ext - `SAMPLE_W'(128)) << 4) + `SAMPLE_W'(8);

	assign o_cmd_take = (state == DEC_IDLE) && i_cmd_valid;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= DEC_IDLE;
			o_arm     <= 1'b0;
			cfg_q     <= '0;
			preoffset <= '0;
		end else begin
			o_arm <= 1'b0;
			case (state)
				DEC_IDLE: if (o_cmd_take) begin
					state <= DEC_REPLY;              // unknown opcodes fall back below
					case (i_cmd.op)
						OP_SETTINGS: begin
							cfg_q.lower <= sample_t'(lower_calc);
							cfg_q.upper <= sample_t'(upper_calc);
							preoffset   <= `BUF_ADDR_W'({i_cmd.arg[3], 2'b00});
						end
						OP_ARM: begin
							cfg_q.thresh_en <= (i_cmd.arg[1] == 8'd1);
							cfg_q.length    <= `CNT_W'({i_cmd.arg[5], i_cmd.arg[4]});
							o_arm           <= 1'b1;
						end
						OP_READOUT, OP_INFO: ;
						default: state <= DEC_IDLE;      // no reply
					endcase
				end
				DEC_REPLY: if (i_reply_take) state <= DEC_BUSY;
				DEC_BUSY:  if (i_reply_done) state <= DEC_IDLE;
				default:   state <= DEC_IDLE;
			endcase
		end
	end

	// reply request built while taking the command
	always_ff @(posedge clk) begin
		if (o_cmd_take) begin
			reply_q.readout <= 1'b0;
			reply_q.word    <= 32'd0;
			reply_q.len     <= `LEN_W'(4);
			reply_q.start   <= i_status.trig_addr - preoffset;  // wraps in the buffer
			case (i_cmd.op)
				OP_READOUT: begin
					reply_q.readout <= 1'b1;
					reply_q.len     <= `LEN_W'({i_cmd.arg[7], i_cmd.arg[6],
					                            i_cmd.arg[5], i_cmd.arg[4]});
				end
				OP_ARM:      reply_q.word <= {i_status.events, i_status.trig_count};
				OP_SETTINGS: reply_q.word <= `SETTINGS_ACK;
				OP_INFO: begin
					if (i_cmd.arg[1] == 8'd0)      reply_q.word <= `FW_VERSION;
					else if (i_cmd.arg[1] == 8'd1) reply_q.word <= {4{i_board_id}};
				end
				default: ;
			endcase
		end
	end

	assign o_reply_valid = (state == DEC_REPLY);
	assign o_reply       = reply_q;
	assign o_trig_cfg    = cfg_q;

endmodule

// ==== logic/cmd_receiver.sv ====
//--------------------------------------------------------------------------
// command receiver
// collects bytes from the stream slave into one command
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "proc_defines.svh"

module cmd_receiver
	import cmd_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_s_tvalid,
	input  logic [7:0] i_s_tdata,
	output logic       o_s_tready,
	input  logic       i_cmd_take,
	output logic       o_cmd_valid,
	output cmd_t       o_cmd
);

	localparam int unsigned IDX_W = $clog2(`CMD_BYTES);
	localparam int unsigned LAST  = `CMD_BYTES - 1;

	logic [IDX_W-1:0]           byte_idx;
	logic [`CMD_BYTES-1:0][7:0] cmd_bytes;
	logic                       pending;   // full command waiting for the decoder
	logic                       ready_q;
	logic                       beat;

	assign beat = i_s_tvalid && ready_q;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_idx <= '0;
			pending  <= 1'b0;
			ready_q  <= 1'b0;
		end else begin
			if (beat) byte_idx <= (byte_idx == LAST[IDX_W-1:0]) ? '0 : byte_idx + 1'b1;
			if (beat && byte_idx == LAST[IDX_W-1:0]) begin
				pending <= 1'b1;
				ready_q <= 1'b0;   // stall until taken
			end else if (i_cmd_take) begin
				pending <= 1'b0;
				ready_q <= 1'b1;
			end else if (!pending) begin
				ready_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (beat) cmd_bytes[byte_idx] <= i_s_tdata;
	end

	assign o_s_tready  = ready_q;
	assign o_cmd_valid = pending;
	assign o_cmd       = cmd_t'(cmd_bytes);

endmodule

// ==== logic/acq_pkg.sv ====
//--------------------------------------------------------------------------
// acquisition side types
// samples, trigger state, trigger settings and event status
//--------------------------------------------------------------------------

`include "proc_defines.svh"

package acq_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;

	typedef enum logic [2:0] {
		ACQ_IDLE,
		ACQ_WAIT_LOW,
		ACQ_WAIT_HIGH,
		ACQ_COLLECT,
		ACQ_READY
	} acq_state_e;

	typedef struct packed {
		sample_t            lower;     // a sample below it starts the trigger
		sample_t            upper;     // a sample above it fires the trigger
		logic               thresh_en; // trigger type 1
		logic [`CNT_W-1:0]  length;    // samples to take after trigger
	} trig_cfg_t;

	typedef struct packed {
		logic [`CNT_W-1:0]      events;     // completed events
		logic [`CNT_W-1:0]      trig_count; // 0 in idle and all ones when ready
		logic [`BUF_ADDR_W-1:0] trig_addr;  // buffer address of the trigger
	} acq_status_t;

endpackage

// ==== logic/cmd_pkg.sv ====
//--------------------------------------------------------------------------
// command side types
// opcodes, the assembled command and the reply request to the sender
//--------------------------------------------------------------------------

`include "proc_defines.svh"

package cmd_pkg;

	typedef enum logic [7:0] {
		OP_READOUT  = 8'd0,             // stream buffer samples
		OP_ARM      = 8'd1,             // trigger type, length, arm, status
		OP_INFO     = 8'd2,             // version or board id
		OP_SETTINGS = 8'd8              // thresholds and pre-offset
	} opcode_e;

	// byte 0 sits in the low bits, as it arrives first
	typedef struct packed {
		logic [`CMD_BYTES-1:1][7:0] arg;   // bytes 7..1
		opcode_e                    op;    // byte 0
	} cmd_t;

	typedef struct packed {
		logic                   readout;   // 1: buffer readout, 0: single word
		logic [31:0]            word;      // constant reply word
		logic [`LEN_W-1:0]      len;       // bytes to send
		logic [`BUF_ADDR_W-1:0] start;     // first buffer address of a readout
	} reply_req_t;

endpackage

// ==== logic/proc_defines.svh ====
//--------------------------------------------------------------------------
// command processor parameters
// buffer and sample widths, counter sizes and fixed reply words
//--------------------------------------------------------------------------

`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

`define CMD_BYTES     8                 // bytes per command
`define SAMPLE_W      12                // signed adc sample
`define BUF_ADDR_W    10                // sample buffer address
`define BUF_DEPTH     (1 << `BUF_ADDR_W)

`define FW_VERSION    32'd16            // info reply for byte1 = 0
`define SETTINGS_ACK  32'd37            // reply to the settings command

`define LEN_W         32                // reply length in bytes
`define CNT_W         16                // trigger and event counters

`endif
